/* verilog/mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// boot rom vector, first fetch after reset
`define MIPS_RESET_PC 32'hbfc00000

`define MIPS_RA 5'd31           // link register for jal

`define MIPS_NOP 32'h00000000   // encodes sll to $0, used for bubbles

`endif

/* verilog/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    typedef logic [31:0] word_t;    // data or address
    typedef logic [4:0] regAddr_t;
    typedef logic [3:0] byteEn_t;   // lane 0 is address bits 00

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } aluOp_t;

    typedef enum logic [1:0] {
        FWD_REG,    // register file value
        FWD_MEM,    // result sitting in M
        FWD_WB      // result sitting in W
    } fwdSel_t;

    typedef enum logic {
        MEM_WORD,
        MEM_BYTE
    } memSize_t;

endpackage

`default_nettype wire

/* verilog/aluUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
    input  mipsPkg::aluOp_t aluOp,
    input  mipsPkg::word_t  srcA,
    input  mipsPkg::word_t  srcB,
    input  logic [4:0]      shamt,
    output mipsPkg::word_t  result
);
    import mipsPkg::*;

    always_comb begin
        case (aluOp)
            ALU_ADD:  result = srcA + srcB;     // no overflow trap
            ALU_SUB:  result = srcA - srcB;
            ALU_AND:  result = srcA & srcB;
            ALU_OR:   result = srcA | srcB;
            ALU_XOR:  result = srcA ^ srcB;
            ALU_NOR:  result = ~(srcA | srcB);
            ALU_SLT:  result = {31'd0, $signed(srcA) < $signed(srcB)};
            ALU_SLTU: result = {31'd0, srcA < srcB};
            ALU_SLL:  result = srcB << shamt;   // shifts act on rt
            ALU_SRL:  result = srcB >> shamt;
            ALU_SRA:  result = $signed(srcB) >>> shamt;
            ALU_LUI:  result = {srcB[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/regFile.sv */
`timescale 1ns/1ns
`default_nettype none

module regFile (
    input  logic              clk,
    input  logic              arstN,
    input  logic              we,
    input  mipsPkg::regAddr_t waddr,
    input  mipsPkg::word_t    wdata,
    input  mipsPkg::regAddr_t raddr1,
    input  mipsPkg::regAddr_t raddr2,
    output mipsPkg::word_t    rdata1,
    output mipsPkg::word_t    rdata2
);
    import mipsPkg::*;

    word_t regs [32];
    logic  wrLive;      // write that actually lands

    assign wrLive = we && (waddr != 5'd0);     // $0 stays zero

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[waddr] <= wdata;
        end
    end

    // decode sees the value that W writes at this edge
    assign rdata1 = (wrLive && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (wrLive && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

/* verilog/instrDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
    input  mipsPkg::word_t    instrD,
    output mipsPkg::aluOp_t   aluOp,
    output logic              useImm,
    output logic              signExt,
    output logic              regWrite,
    output logic              dstRt,
    output logic              link,
    output logic              memRead,
    output logic              memWrite,
    output mipsPkg::memSize_t memSize,
    output logic              loadSigned,
    output logic              isBranch,
    output logic              branchNe,
    output logic              isJump,
    output logic              isJr,
    output logic              useShamt,
    output mipsPkg::word_t    immD
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instrD[31:26];
    assign funct  = instrD[5:0];
    assign immD   = signExt ? {{16{instrD[15]}}, instrD[15:0]} : {16'h0000, instrD[15:0]};

    always_comb begin
        aluOp      = ALU_ADD;
        useImm     = 1'b0;
        signExt    = 1'b0;
        regWrite   = 1'b0;
        dstRt      = 1'b0;
        link       = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        memSize    = MEM_WORD;
        loadSigned = 1'b0;
        isBranch   = 1'b0;
        branchNe   = 1'b0;
        isJump     = 1'b0;
        isJr       = 1'b0;
        useShamt   = 1'b0;
        case (opcode)
            6'b000000: begin    // special, decoded by funct
                regWrite = 1'b1;
                case (funct)
                    6'b100001: aluOp = ALU_ADD;
                    6'b100011: aluOp = ALU_SUB;
                    6'b100100: aluOp = ALU_AND;
                    6'b100101: aluOp = ALU_OR;
                    6'b100110: aluOp = ALU_XOR;
                    6'b100111: aluOp = ALU_NOR;
                    6'b101010: aluOp = ALU_SLT;
                    6'b101011: aluOp = ALU_SLTU;
                    6'b000000: {aluOp, useShamt} = {ALU_SLL, 1'b1};
                    6'b000010: {aluOp, useShamt} = {ALU_SRL, 1'b1};
                    6'b000011: {aluOp, useShamt} = {ALU_SRA, 1'b1};
                    6'b001000: {regWrite, isJr} = 2'b01;    // jr
                    6'b001001: {link, isJr} = 2'b11;        // jalr, links into rd
                    default:   regWrite = 1'b0;
                endcase
            end
            6'b001001: {useImm, signExt, regWrite, dstRt} = 4'b1111;   // addiu
            6'b001010: begin    // slti
                aluOp = ALU_SLT;
                {useImm, signExt, regWrite, dstRt} = 4'b1111;
            end
            6'b001100: {aluOp, useImm, regWrite, dstRt} = {ALU_AND, 3'b111};
            6'b001101: {aluOp, useImm, regWrite, dstRt} = {ALU_OR, 3'b111};
            6'b001110: {aluOp, useImm, regWrite, dstRt} = {ALU_XOR, 3'b111};
            6'b001111: {aluOp, useImm, regWrite, dstRt} = {ALU_LUI, 3'b111};
            6'b100011: {useImm, signExt, regWrite, dstRt, memRead} = 5'b11111;  // lw
            6'b100000: begin    // lb
                {useImm, signExt, regWrite, dstRt, memRead} = 5'b11111;
                memSize    = MEM_BYTE;
                loadSigned = 1'b1;
            end
            6'b100100: begin    // lbu
                {useImm, signExt, regWrite, dstRt, memRead} = 5'b11111;
                memSize = MEM_BYTE;
            end
            6'b101011: {useImm, signExt, memWrite} = 3'b111;  // sw
            6'b101000: begin    // sb
                {useImm, signExt, memWrite} = 3'b111;
                memSize = MEM_BYTE;
            end
            6'b000100: {isBranch, signExt} = 2'b11;   // beq
            6'b000101: {isBranch, signExt, branchNe} = 3'b111;
            6'b000010: isJump = 1'b1;
            6'b000011: {isJump, link, regWrite} = 3'b111;     // jal
            default: ;  // unknown opcode leaves a nop
        endcase
    end

endmodule

`default_nettype wire

/* verilog/hazardUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
    input  mipsPkg::regAddr_t rsE,
    input  mipsPkg::regAddr_t rtE,
    input  mipsPkg::regAddr_t rsD,
    input  mipsPkg::regAddr_t rtD,
    input  mipsPkg::regAddr_t writeRegE,
    input  logic              memReadE,
    input  mipsPkg::regAddr_t writeRegM,
    input  logic              regWriteM,
    input  mipsPkg::regAddr_t writeRegW,
    input  logic              regWriteW,
    input  logic              redirectE,
    output mipsPkg::fwdSel_t  fwdA,
    output mipsPkg::fwdSel_t  fwdB,
    output logic              stallF,
    output logic              stallD,
    output logic              flushD,
    output logic              flushE
);
    import mipsPkg::*;

    logic loadUse;

    // youngest producer wins, $0 never forwarded
    function automatic fwdSel_t pickFwd(input regAddr_t src, input regAddr_t regM,
                                        input logic weM, input regAddr_t regW,
                                        input logic weW);
        if (weM && regM != 5'd0 && regM == src) begin
            return FWD_MEM;
        end else if (weW && regW != 5'd0 && regW == src) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwdA = pickFwd(rsE, writeRegM, regWriteM, writeRegW, regWriteW);
        fwdB = pickFwd(rtE, writeRegM, regWriteM, writeRegW, regWriteW);
    end

    // load data only exists in M, so the consumer waits one cycle
    assign loadUse = memReadE && writeRegE != 5'd0 && (writeRegE == rsD || writeRegE == rtD);

    assign stallF = loadUse;
    assign stallD = loadUse;
    assign flushE = loadUse;    // bubble into E
    assign flushD = redirectE;  // drop the fetch after the delay slot

    always_comb begin
        assert final (!(stallD && flushD))
            else $error("decode stall and flush raised together");
    end

endmodule

`default_nettype wire

/* verilog/memAccess.sv */
`timescale 1ns/1ns
`default_nettype none

module memAccess (
    input  logic              memReadM,
    input  logic              memWriteM,
    input  mipsPkg::memSize_t memSizeM,
    input  logic              loadSignedM,
    input  mipsPkg::word_t    addrM,
    input  mipsPkg::word_t    storeDataM,
    input  mipsPkg::word_t    memRdata,
    output logic              memEn,
    output mipsPkg::byteEn_t  memWen,
    output mipsPkg::word_t    memWdata,
    output mipsPkg::word_t    loadDataM
);
    import mipsPkg::*;

    logic [1:0] lane;
    logic [7:0] loadByte;

    assign lane     = addrM[1:0];
    assign memEn    = memReadM | memWriteM;
    assign loadByte = memRdata[8*lane +: 8];

    // byte stores put the same byte on every lane, the strobe picks one
    assign memWdata = (memSizeM == MEM_BYTE) ? {4{storeDataM[7:0]}} : storeDataM;

    always_comb begin
        memWen = 4'b0000;
        if (memWriteM) begin
            memWen = (memSizeM == MEM_BYTE) ? 4'b0001 << lane : 4'b1111;
        end
    end

    assign loadDataM = (memSizeM == MEM_WORD) ? memRdata
                                              : {{24{loadSignedM & loadByte[7]}}, loadByte};

    always_comb begin
        if (memEn && memSizeM == MEM_WORD) begin
            assert final (lane == 2'b00)
                else $error("word access at unaligned address %h", addrM);
        end
    end

endmodule

`default_nettype wire

/* verilog/fetchUnit.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mips_cfg.svh"

module fetchUnit (
    input  logic           clk,
    input  logic           arstN,
    input  logic           stallF,
    input  logic           stallD,
    input  logic           flushD,
    input  logic           jumpD,
    input  mipsPkg::word_t jumpTargetD,
    input  logic           redirectE,
    input  mipsPkg::word_t redirectTargetE,
    input  mipsPkg::word_t instr,
    input  logic           controlD,
    output mipsPkg::word_t instAddr,
    output logic           instEn,
    output mipsPkg::word_t pcD,
    output mipsPkg::word_t instrD,
    output logic           inDelaySlotD
);
    import mipsPkg::*;

    word_t pcF;
    word_t pcNext;
    logic  fetchOn;     // rises one cycle after reset release

    assign instAddr = pcF;
    assign instEn   = fetchOn & ~stallF;

    always_comb begin
        if (redirectE) begin
            pcNext = redirectTargetE;   // taken branch or jr from E
        end else if (jumpD) begin
            pcNext = jumpTargetD;       // j and jal, delay slot already in F
        end else begin
            pcNext = pcF + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fetchOn <= 1'b0;
            pcF     <= `MIPS_RESET_PC;
        end else begin
            fetchOn <= 1'b1;
            if (fetchOn && !stallF) begin
                pcF <= pcNext;
            end
        end
    end

    // F/D register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrD       <= `MIPS_NOP;
            inDelaySlotD <= 1'b0;
        end else if (flushD || !fetchOn) begin
            instrD       <= `MIPS_NOP;  // squash wrong-path fetch
            inDelaySlotD <= 1'b0;
        end else if (!stallD) begin
            instrD       <= instr;
            inDelaySlotD <= controlD;   // follows a branch or jump
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD) begin
            pcD <= pcF;
        end
    end

    assert property (@(posedge clk) disable iff (!arstN) instAddr[1:0] == 2'b00)
        else $error("fetch address %h is not word aligned", instAddr);

endmodule

`default_nettype wire

/* verilog/datapath.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mips_cfg.svh"

module datapath (
    input  logic             clk,
    input  logic             arstN,
    output mipsPkg::word_t   instAddr,
    output logic             instEn,
    input  mipsPkg::word_t   instr,
    output logic             memEn,
    output mipsPkg::word_t   memAddr,
    input  mipsPkg::word_t   memRdata,
    output mipsPkg::byteEn_t memWen,
    output mipsPkg::word_t   memWdata,
    output mipsPkg::word_t   aluOut,
    output mipsPkg::word_t   writeData
);
    import mipsPkg::*;

    // decode stage
    word_t    pcD, instrD, immD, jumpTargetD, pcPlus4D;
    word_t    rd1D, rd2D;
    regAddr_t rsD, rtD, writeRegD;
    aluOp_t   aluOpD;
    memSize_t memSizeD;
    logic     useImmD, regWriteD, dstRtD, linkD, memReadD, memWriteD, loadSignedD;
    logic     isBranchD, branchNeD, isJumpD, isJrD, useShamtD, controlD, inDelaySlotD;
    logic     stallF, stallD, flushD, flushE;

    // execute stage
    word_t    pcE, rd1E, rd2E, immE, srcAE, srcBE, srcBAluE, aluResE, resultE;
    word_t    redirectTargetE;
    regAddr_t rsE, rtE, writeRegE;
    logic [4:0] shamtE;
    aluOp_t   aluOpE;
    memSize_t memSizeE;
    fwdSel_t  fwdA, fwdB;
    logic     useImmE, regWriteE, linkE, memReadE, memWriteE, loadSignedE;
    logic     isBranchE, branchNeE, isJrE, redirectE;

    // memory and writeback stages
    word_t    aluOutM, writeDataM, loadDataM, aluOutW, loadDataW, resultW;
    regAddr_t writeRegM, writeRegW;
    memSize_t memSizeM;
    logic     regWriteM, memReadM, memWriteM, loadSignedM, regWriteW, memReadW;

    fetchUnit fetch (
        .clk(clk), .arstN(arstN), .stallF(stallF), .stallD(stallD), .flushD(flushD),
        .jumpD(isJumpD), .jumpTargetD(jumpTargetD),
        .redirectE(redirectE), .redirectTargetE(redirectTargetE),
        .instr(instr), .controlD(controlD), .instAddr(instAddr), .instEn(instEn),
        .pcD(pcD), .instrD(instrD), .inDelaySlotD(inDelaySlotD)
    );

    instrDecoder decoder (
        .instrD(instrD), .aluOp(aluOpD), .useImm(useImmD), .signExt(),
        .regWrite(regWriteD), .dstRt(dstRtD), .link(linkD),
        .memRead(memReadD), .memWrite(memWriteD), .memSize(memSizeD),
        .loadSigned(loadSignedD), .isBranch(isBranchD), .branchNe(branchNeD),
        .isJump(isJumpD), .isJr(isJrD), .useShamt(useShamtD), .immD(immD)
    );

    regFile regs (
        .clk(clk), .arstN(arstN), .we(regWriteW), .waddr(writeRegW), .wdata(resultW),
        .raddr1(rsD), .raddr2(rtD), .rdata1(rd1D), .rdata2(rd2D)
    );

    assign rsD         = instrD[25:21];
    assign rtD         = instrD[20:16];
    assign pcPlus4D    = pcD + 32'd4;
    assign jumpTargetD = {pcPlus4D[31:28], instrD[25:0], 2'b00};  // region of the delay slot
    assign controlD    = isBranchD | isJumpD | isJrD;
    assign writeRegD   = (linkD && isJumpD) ? `MIPS_RA : (dstRtD ? rtD : instrD[15:11]);

    // D/E register, control half
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            {regWriteE, memReadE, memWriteE, isBranchE, isJrE} <= '0;
        end else if (flushE) begin
            {regWriteE, memReadE, memWriteE, isBranchE, isJrE} <= '0;   // load-use bubble
        end else begin
            {regWriteE, memReadE, memWriteE} <= {regWriteD, memReadD, memWriteD};
            {isBranchE, isJrE}                <= {isBranchD, isJrD};
        end
    end

    // D/E register, payload half
    always_ff @(posedge clk) begin
        pcE         <= pcD;
        rd1E        <= rd1D;
        rd2E        <= rd2D;
        immE        <= immD;
        rsE         <= rsD;
        rtE         <= rtD;
        writeRegE   <= writeRegD;
        shamtE      <= useShamtD ? instrD[10:6] : 5'd0;
        aluOpE      <= aluOpD;
        memSizeE    <= memSizeD;
        useImmE     <= useImmD;
        linkE       <= linkD;
        loadSignedE <= loadSignedD;
        branchNeE   <= branchNeD;
    end

    hazardUnit hazard (
        .rsE(rsE), .rtE(rtE), .rsD(rsD), .rtD(rtD),
        .writeRegE(writeRegE), .memReadE(memReadE),
        .writeRegM(writeRegM), .regWriteM(regWriteM),
        .writeRegW(writeRegW), .regWriteW(regWriteW), .redirectE(redirectE),
        .fwdA(fwdA), .fwdB(fwdB), .stallF(stallF), .stallD(stallD),
        .flushD(flushD), .flushE(flushE)
    );

    always_comb begin
        case (fwdA)
            FWD_MEM: srcAE = aluOutM;
            FWD_WB:  srcAE = resultW;
            default: srcAE = rd1E;
        endcase
        case (fwdB)
            FWD_MEM: srcBE = aluOutM;
            FWD_WB:  srcBE = resultW;
            default: srcBE = rd2E;
        endcase
    end

    assign srcBAluE = useImmE ? immE : srcBE;

    aluUnit alu (
        .aluOp(aluOpE), .srcA(srcAE), .srcB(srcBAluE), .shamt(shamtE), .result(aluResE)
    );

    assign resultE = linkE ? pcE + 32'd8 : aluResE;   // return lands past the delay slot

    // beq/bne compare forwarded operands, jr/jalr always redirect
    assign redirectE = (isBranchE && ((srcAE == srcBE) != branchNeE)) || isJrE;
    assign redirectTargetE = isJrE ? srcAE : pcE + 32'd4 + {immE[29:0], 2'b00};

    // E/M register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            {regWriteM, memReadM, memWriteM} <= '0;
        end else begin
            {regWriteM, memReadM, memWriteM} <= {regWriteE, memReadE, memWriteE};
        end
    end

    always_ff @(posedge clk) begin
        aluOutM     <= resultE;
        writeDataM  <= srcBE;       // rt after forwarding
        writeRegM   <= writeRegE;
        memSizeM    <= memSizeE;
        loadSignedM <= loadSignedE;
    end

    memAccess memCtrl (
        .memReadM(memReadM), .memWriteM(memWriteM), .memSizeM(memSizeM),
        .loadSignedM(loadSignedM), .addrM(aluOutM), .storeDataM(writeDataM),
        .memRdata(memRdata), .memEn(memEn), .memWen(memWen), .memWdata(memWdata),
        .loadDataM(loadDataM)
    );

    assign memAddr   = aluOutM;
    assign aluOut    = aluOutM;
    assign writeData = writeDataM;

    // M/W register
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            {regWriteW, memReadW} <= '0;
        end else begin
            {regWriteW, memReadW} <= {regWriteM, memReadM};
        end
    end

    always_ff @(posedge clk) begin
        aluOutW   <= aluOutM;
        loadDataW <= loadDataM;
        writeRegW <= writeRegM;
    end

    assign resultW = memReadW ? loadDataW : aluOutW;

    assert property (@(posedge clk) disable iff (!arstN) (memWen != 4'b0000) |-> memEn)
        else $error("byte strobes %b without memory enable", memWen);

    // a branch in E always has its delay slot right behind it in D
    assert property (@(posedge clk) disable iff (!arstN) (isBranchE || isJrE) |-> inDelaySlotD)
        else $error("branch in execute without a delay slot in decode");

endmodule

`default_nettype wire

/* sim/tbProgram.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int STORE_COUNT = 17;

word_t   expAddr [STORE_COUNT];
byteEn_t expWen  [STORE_COUNT];
word_t   expData [STORE_COUNT];     // only enabled lanes are compared

task automatic expectStore(input int idx, input word_t addr, input byteEn_t wen,
                           input word_t data);
    expAddr[idx] = addr;
    expWen[idx]  = wen;
    expData[idx] = data;
endtask

// program from the reset vector, then the stores it makes, in order
task automatic loadProgram();
    rom[0]  = encI(6'h09, 5'd0, 5'd1, 16'h0005);         // addiu $1, $0, 5
    rom[1]  = encI(6'h09, 5'd1, 5'd2, 16'hfffe);         // addiu $2, $1, -2
    rom[2]  = encR(5'd1, 5'd2, 5'd3, 5'd0, 6'h21);       // addu $3, $1, $2
    rom[3]  = encI(6'h2b, 5'd0, 5'd3, 16'h0100);         // sw $3, 0x100($0)
    rom[4]  = encR(5'd2, 5'd3, 5'd4, 5'd0, 6'h23);       // subu $4, $2, $3
    rom[5]  = encI(6'h2b, 5'd0, 5'd4, 16'h0104);         // sw $4
    rom[6]  = encR(5'd3, 5'd1, 5'd5, 5'd0, 6'h27);       // nor $5, $3, $1
    rom[7]  = encI(6'h2b, 5'd0, 5'd5, 16'h0108);         // sw $5
    rom[8]  = encR(5'd4, 5'd1, 5'd6, 5'd0, 6'h2a);       // slt $6, $4, $1
    rom[9]  = encR(5'd4, 5'd1, 5'd7, 5'd0, 6'h2b);       // sltu $7, $4, $1
    rom[10] = encR(5'd0, 5'd6, 5'd8, 5'd5, 6'h00);       // sll $8, $6, 5
    rom[11] = encR(5'd8, 5'd7, 5'd8, 5'd0, 6'h21);       // addu $8, $8, $7
    rom[12] = encI(6'h2b, 5'd0, 5'd8, 16'h010c);         // sw $8
    rom[13] = encR(5'd0, 5'd4, 5'd9, 5'd1, 6'h03);       // sra $9, $4, 1
    rom[14] = encI(6'h2b, 5'd0, 5'd9, 16'h0110);         // sw $9
    rom[15] = encI(6'h0f, 5'd0, 5'd10, 16'h8765);        // lui $10, 0x8765
    rom[16] = encI(6'h0d, 5'd10, 5'd10, 16'hfff0);       // ori, zero extended
    rom[17] = encI(6'h2b, 5'd0, 5'd10, 16'h0114);        // sw $10
    rom[18] = encI(6'h0c, 5'd10, 5'd11, 16'hff0f);       // andi $11, $10, 0xff0f
    rom[19] = encI(6'h0e, 5'd11, 5'd11, 16'h8001);       // xori $11, $11, 0x8001
    rom[20] = encI(6'h0a, 5'd1, 5'd12, 16'hfffc);        // slti $12, $1, -4
    rom[21] = encR(5'd12, 5'd11, 5'd13, 5'd0, 6'h21);    // addu $13, $12, $11
    rom[22] = encI(6'h2b, 5'd0, 5'd13, 16'h0118);        // sw $13
    rom[23] = encI(6'h23, 5'd0, 5'd14, 16'h0114);        // lw $14, 0x114($0)
    rom[24] = encR(5'd14, 5'd1, 5'd15, 5'd0, 6'h21);     // load-use addu
    rom[25] = encI(6'h2b, 5'd0, 5'd15, 16'h011c);        // sw $15
    rom[26] = encI(6'h09, 5'd0, 5'd16, 16'h0080);        // addiu $16, $0, 0x80
    rom[27] = encI(6'h28, 5'd0, 5'd16, 16'h0121);        // sb into lane 1
    rom[28] = encI(6'h20, 5'd0, 5'd17, 16'h0121);        // lb $17
    rom[29] = encI(6'h2b, 5'd0, 5'd17, 16'h0124);        // sw $17
    rom[30] = encI(6'h24, 5'd0, 5'd18, 16'h0121);        // lbu $18
    rom[31] = encI(6'h2b, 5'd0, 5'd18, 16'h0128);        // sw $18
    rom[32] = encI(6'h04, 5'd1, 5'd1, 16'h0002);         // beq taken, to 35
    rom[33] = encI(6'h2b, 5'd0, 5'd2, 16'h012c);         // delay slot
    rom[34] = encI(6'h2b, 5'd0, 5'd3, 16'h01fc);         // must be squashed
    rom[35] = encI(6'h05, 5'd1, 5'd2, 16'h0002);         // bne taken, to 38
    rom[36] = encI(6'h2b, 5'd0, 5'd1, 16'h0130);         // delay slot
    rom[37] = encI(6'h2b, 5'd0, 5'd3, 16'h01fc);         // must be squashed
    rom[38] = encI(6'h04, 5'd1, 5'd2, 16'h0002);         // beq not taken
    rom[39] = encI(6'h2b, 5'd0, 5'd6, 16'h0134);         // delay slot
    rom[40] = encI(6'h2b, 5'd0, 5'd9, 16'h0138);         // fall through
    rom[41] = encJ(6'h03, 46);                           // jal to 46
    rom[42] = encI(6'h09, 5'd0, 5'd20, 16'h0007);        // delay slot
    rom[43] = encI(6'h2b, 5'd0, 5'd20, 16'h013c);        // return point
    rom[44] = encJ(6'h02, 44);                           // j to itself
    rom[45] = `MIPS_NOP;
    rom[46] = encI(6'h2b, 5'd0, 5'd31, 16'h0140);        // sw $ra
    rom[47] = encR(5'd31, 5'd0, 5'd0, 5'd0, 6'h08);      // jr $ra
    rom[48] = `MIPS_NOP;

    expectStore(0, 32'h00000100, 4'b1111, 32'h00000008);
    expectStore(1, 32'h00000104, 4'b1111, 32'hfffffffb);
    expectStore(2, 32'h00000108, 4'b1111, 32'hfffffff2);
    expectStore(3, 32'h0000010c, 4'b1111, 32'h00000020);
    expectStore(4, 32'h00000110, 4'b1111, 32'hfffffffd);
    expectStore(5, 32'h00000114, 4'b1111, 32'h8765fff0);
    expectStore(6, 32'h00000118, 4'b1111, 32'h00007f01);
    expectStore(7, 32'h0000011c, 4'b1111, 32'h8765fff5);
    expectStore(8, 32'h00000121, 4'b0010, 32'h00008000);
    expectStore(9, 32'h00000124, 4'b1111, 32'hffffff80);
    expectStore(10, 32'h00000128, 4'b1111, 32'h00000080);
    expectStore(11, 32'h0000012c, 4'b1111, 32'h00000003);
    expectStore(12, 32'h00000130, 4'b1111, 32'h00000005);
    expectStore(13, 32'h00000134, 4'b1111, 32'h00000001);
    expectStore(14, 32'h00000138, 4'b1111, 32'hfffffffd);
    expectStore(15, 32'h00000140, 4'b1111, `MIPS_RESET_PC + 32'h000000ac);
    expectStore(16, 32'h0000013c, 4'b1111, 32'h00000007);
endtask

`endif

/* sim/tbDatapath.sv */
`timescale 1ns/1ns
`default_nettype none
`include "mips_cfg.svh"

module tbDatapath;
    import mipsPkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int ROM_WORDS  = 64;
    localparam int RAM_WORDS  = 256;

    logic    clk;
    logic    arstN;
    word_t   instAddr;
    logic    instEn;
    word_t   instr;
    logic    memEn;
    word_t   memAddr;
    word_t   memRdata;
    byteEn_t memWen;
    word_t   memWdata;
    word_t   aluOut;
    word_t   writeData;

    word_t rom [ROM_WORDS];
    word_t ram [RAM_WORDS];
    word_t romOffset;

    function automatic word_t encR(input regAddr_t rs, input regAddr_t rt, input regAddr_t rd,
                                   input logic [4:0] sh, input logic [5:0] funct);
        return {6'b000000, rs, rt, rd, sh, funct};
    endfunction

    function automatic word_t encI(input logic [5:0] op, input regAddr_t rs, input regAddr_t rt,
                                   input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // target is a word index into the program
    function automatic word_t encJ(input logic [5:0] op, input int idx);
        word_t target;
        target = `MIPS_RESET_PC + 4 * idx;
        return {op, target[27:2]};
    endfunction

    `include "tbProgram.svh"

    function automatic word_t laneMask(input byteEn_t wen);
        word_t mask;
        for (int lane = 0; lane < 4; lane++) begin
            mask[8*lane +: 8] = {8{wen[lane]}};
        end
        return mask;
    endfunction

    // the one enabled byte of a byte store, moved down to bits 7:0
    function automatic logic [7:0] storedByte(input word_t data, input byteEn_t wen);
        word_t lanes;
        lanes = data & laneMask(wen);
        return lanes[31:24] | lanes[23:16] | lanes[15:8] | lanes[7:0];
    endfunction

    task automatic abortRun();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic reportValue(input string name, input word_t expected, input word_t actual);
        $display("FAILED at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        abortRun();
    endtask

    datapath uut (
        .clk(clk), .arstN(arstN),
        .instAddr(instAddr), .instEn(instEn), .instr(instr),
        .memEn(memEn), .memAddr(memAddr), .memRdata(memRdata),
        .memWen(memWen), .memWdata(memWdata),
        .aluOut(aluOut), .writeData(writeData)
    );

    // instruction ROM and data RAM, both read combinationally
    assign romOffset = instAddr - `MIPS_RESET_PC;
    assign instr     = (romOffset < 4 * ROM_WORDS) ? rom[romOffset[7:2]] : `MIPS_NOP;
    assign memRdata  = ram[memAddr[9:2]];

    always @(posedge clk) begin
        if (memWen != 4'b0000) begin
            ram[memAddr[9:2]] <= (ram[memAddr[9:2]] & ~laneMask(memWen))
                               | (memWdata & laneMask(memWen));
        end
    end

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        arstN = 1'b0;
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram[i] = 32'hda7a0000 | (i << 2);   // byte address in low bits
        end
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = `MIPS_NOP;
        end
        loadProgram();
        repeat (10) @(posedge clk);
        #1 arstN = 1'b1;
    end

    initial begin : storeCheck
        word_t      mask;
        logic [7:0] expByte;
        while (arstN !== 1'b1) begin
            @(negedge clk);
            assert (memEn === 1'b0) else reportValue("memEn", 32'd0, {31'd0, memEn});
            assert (memWen === 4'b0000) else reportValue("memWen", 32'd0, {28'd0, memWen});
        end
        do begin
            @(negedge clk);
        end while (instEn !== 1'b1);
        assert (instAddr === `MIPS_RESET_PC)
            else reportValue("instAddr", `MIPS_RESET_PC, instAddr);

        for (int idx = 0; idx < STORE_COUNT; idx++) begin
            do begin
                @(negedge clk);
            end while (memWen === 4'b0000);     // next store cycle
            mask = laneMask(expWen[idx]);
            assert (memEn === 1'b1) else reportValue("memEn", 32'd1, {31'd0, memEn});
            assert (memAddr === expAddr[idx])
                else reportValue("memAddr", expAddr[idx], memAddr);
            assert (aluOut === expAddr[idx])
                else reportValue("aluOut", expAddr[idx], aluOut);
            assert (memWen === expWen[idx])
                else reportValue("memWen", {28'd0, expWen[idx]}, {28'd0, memWen});
            assert ((memWdata & mask) === (expData[idx] & mask))
                else reportValue("memWdata", expData[idx] & mask, memWdata & mask);
            if (expWen[idx] == 4'b1111) begin
                assert (writeData === expData[idx])
                    else reportValue("writeData", expData[idx], writeData);
            end else begin
                // sb takes the low byte of rt
                expByte = storedByte(expData[idx], expWen[idx]);
                assert (writeData[7:0] === expByte)
                    else reportValue("writeData", {24'd0, expByte}, {24'd0, writeData[7:0]});
            end
        end

        // end loop must stay quiet
        repeat (20) begin
            @(negedge clk);
            assert (memWen === 4'b0000) else begin
                $display("An extra store to address %h appeared at %0t ns", memAddr, $time);
                abortRun();
            end
        end
        $display("No errors");
        $finish;
    end

    initial begin : watchdog
        #((STORE_COUNT * 40 + 30) * CLK_PERIOD);
        $display("Timeout: the expected stores did not all arrive in time");
        abortRun();
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+verilog
+incdir+sim
verilog/mipsPkg.sv
verilog/aluUnit.sv
verilog/regFile.sv
verilog/instrDecoder.sv
verilog/hazardUnit.sv
verilog/memAccess.sv
verilog/fetchUnit.sv
verilog/datapath.sv
sim/tbDatapath.sv
